/* vlog.f */
+incdir+dv
source/uart_pkg.sv
source/bit_timer.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
dv/tb_uart.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_uart_tests.svh */
task automatic expect_good(input string name, input uart_char_t ch, input logic got_valid,
                           input rx_error_t got_error, input uart_char_t got_char);
    if (!got_valid && got_error == '0) begin
        note_failure({name, ": no rx_valid or rx_error pulse"});
    end else begin
        check_error(name, '0, got_error);
        check_char(name, ch & data_mask(cfg.char_size), got_char);
    end
endtask

task automatic expect_error(input string name, input rx_error_t expected,
                            input logic got_valid, input rx_error_t got_error);
    if (!got_valid && got_error == '0) begin
        note_failure({name, ": no rx_error pulse"});
    end else begin
        check_bit({name, " rx_valid"}, 1'b0, got_valid);
        check_error(name, expected, got_error);
    end
endtask

task automatic test_reset_state();
    check_bit("reset txd", 1'b1, txd);
    check_bit("reset tx_busy", 1'b0, tx_busy);
    check_bit("reset tx_done", 1'b0, tx_done);
    check_bit("reset rx_valid", 1'b0, rx_valid);
    check_error("reset rx_error", '0, rx_error);
endtask

task automatic test_tx_framing();
    logic [31:0] r;
    logic        got_valid;
    rx_error_t   got_error;
    uart_char_t  got_char;
    for (int k = 0; k < 16; k++) begin
        r = $urandom;
        // size, parity enable, random polarity, stop bits.
        cfg = line_cfg_t'({k[3:1], r[0], k[0]});
        run_frame($sformatf("framing cfg %b", cfg), uart_char_t'($urandom), 1'b0,
                  1'b0, 1'b0, got_valid, got_error, got_char);
    end
endtask

task automatic test_loopback();
    string      name;
    uart_char_t ch;
    logic       got_valid;
    rx_error_t  got_error;
    uart_char_t got_char;
    for (int k = 0; k < 32; k++) begin
        cfg = line_cfg_t'(k[4:0]);
        for (int j = 0; j < 2; j++) begin
            ch = uart_char_t'($urandom);
            name = $sformatf("loopback cfg %b", cfg);
            run_frame(name, ch, 1'b0, 1'b0, 1'b0, got_valid, got_error, got_char);
            expect_good(name, ch, got_valid, got_error, got_char);
        end
    end
endtask

task automatic test_parity_error();
    rx_error_t  expected;
    uart_char_t ch;
    logic       got_valid;
    rx_error_t  got_error;
    uart_char_t got_char;
    expected = '0;
    expected.parity_err = 1'b1;
    for (int odd = 0; odd < 2; odd++) begin
        cfg.char_size = (odd == 0) ? CHAR_8 : CHAR_6;
        cfg.parity_en = 1'b1;
        cfg.parity_odd = (odd != 0);
        cfg.two_stop = 1'b0;
        idle_bits(3);
        run_frame("parity error", uart_char_t'($urandom), 1'b1, 1'b1, 1'b0,
                  got_valid, got_error, got_char);
        expect_error("parity error", expected, got_valid, got_error);
        idle_bits(3);
        ch = uart_char_t'($urandom);
        run_frame("after parity error", ch, 1'b1, 1'b0, 1'b0, got_valid, got_error, got_char);
        expect_good("after parity error", ch, got_valid, got_error, got_char);
    end
endtask

task automatic test_stop_error();
    rx_error_t  expected;
    uart_char_t ch;
    logic       got_valid;
    rx_error_t  got_error;
    uart_char_t got_char;
    expected = '0;
    expected.stop_err = 1'b1;
    cfg = '0;
    cfg.char_size = CHAR_7;
    idle_bits(3);
    run_frame("stop error", uart_char_t'($urandom), 1'b1, 1'b0, 1'b1,
              got_valid, got_error, got_char);
    expect_error("stop error", expected, got_valid, got_error);
    idle_bits(3);
    ch = uart_char_t'($urandom);
    run_frame("after stop error", ch, 1'b1, 1'b0, 1'b0, got_valid, got_error, got_char);
    expect_good("after stop error", ch, got_valid, got_error, got_char);
endtask

task automatic test_line_low();
    rx_error_t  expected;
    uart_char_t ch;
    logic       got_valid;
    rx_error_t  got_error;
    uart_char_t got_char;
    expected = '0;
    expected.line_low = 1'b1;
    got_valid = 1'b0;
    got_error = '0;
    // line held low through reset, so the hunt never sees idle.
    loop_sel = 1'b0;
    bb_line = 1'b0;
    apply_reset();
    for (int n = 0; n < 3 * BIT_CLOCKS; n++) begin
        if (rx_valid || rx_error != '0) begin
            got_valid = rx_valid;
            got_error = rx_error;
            break;
        end
        next_clocks(1);
    end
    expect_error("line low", expected, got_valid, got_error);
    cfg = '0;
    cfg.char_size = CHAR_8;
    cfg.parity_en = 1'b1;
    idle_bits(3);
    ch = uart_char_t'($urandom);
    run_frame("after line low", ch, 1'b1, 1'b0, 1'b0, got_valid, got_error, got_char);
    expect_good("after line low", ch, got_valid, got_error, got_char);
endtask

/* dv/tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

    import uart_pkg::*;

    localparam int BAUD_WIDTH = 21;
    localparam int BIT_CLOCKS = 10;
    localparam int CLOCK_NS = 20;
    localparam int RESET_CYCLES = 8;

    // framing 16, loopback 64, parity 4, stop 2, line low 1.
    localparam int N_FRAMES = 87;
    localparam int WATCHDOG_NS = N_FRAMES * 12 * BIT_CLOCKS * CLOCK_NS * 2
                               + RESET_CYCLES * CLOCK_NS;

    logic                  clock;
    logic                  reset_in;
    logic [BAUD_WIDTH-1:0] baud_div;
    line_cfg_t             cfg;
    uart_char_t            tx_char;
    logic                  tx_load;
    logic                  txd;
    logic                  tx_busy;
    logic                  tx_done;
    logic                  rxd;
    uart_char_t            rx_char;
    logic                  rx_valid;
    rx_error_t             rx_error;

    logic loop_sel;
    logic bb_line;
    int   error_count;

    // rxd comes from the transmitter or from the bit-bang line.
    assign rxd = loop_sel ? txd : bb_line;

    uart_top #(
        .BAUD_WIDTH(BAUD_WIDTH)
    ) u_uart_top (
        .clock   (clock),
        .reset_in(reset_in),
        .baud_div(baud_div),
        .cfg     (cfg),
        .tx_char (tx_char),
        .tx_load (tx_load),
        .txd     (txd),
        .tx_busy (tx_busy),
        .tx_done (tx_done),
        .rxd     (rxd),
        .rx_char (rx_char),
        .rx_valid(rx_valid),
        .rx_error(rx_error)
    );

    always #(CLOCK_NS / 2) clock = ~clock;

    // inputs change 2 ns after the edge.
    task automatic next_clocks(input int n);
        repeat (n) @(posedge clock);
        #2;
    endtask

    task automatic apply_reset();
        reset_in = 1'b1;
        next_clocks(RESET_CYCLES);
        reset_in = 1'b0;
    endtask

    task automatic idle_bits(input int n);
        loop_sel = 1'b0;
        bb_line = 1'b1;
        next_clocks(n * BIT_CLOCKS);
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic check_char(input string name, input uart_char_t expected,
                              input uart_char_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_error(input string name, input rx_error_t expected,
                               input rx_error_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected error %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic int data_bits(input char_size_t size);
        case (size)
            CHAR_5: return 5;
            CHAR_6: return 6;
            CHAR_7: return 7;
            default: return 8;
        endcase
    endfunction

    function automatic uart_char_t data_mask(input char_size_t size);
        return uart_char_t'((9'd1 << data_bits(size)) - 9'd1);
    endfunction

    function automatic logic parity_of(input uart_char_t ch, input line_cfg_t c);
        return (^(ch & data_mask(c.char_size))) ^ c.parity_odd;
    endfunction

    function automatic int frame_length(input line_cfg_t c);
        return 1 + data_bits(c.char_size) + int'(c.parity_en) + (c.two_stop ? 2 : 1);
    endfunction

    // bit 0 is the start bit; unused upper bits stay idle high.
    function automatic logic [11:0] frame_bits(input uart_char_t ch, input line_cfg_t c,
                                               input logic bad_parity, input logic bad_stop);
        logic [11:0] f;
        int          pos;
        f = '1;
        f[0] = 1'b0;
        pos = 1;
        for (int i = 0; i < data_bits(c.char_size); i++) begin
            f[pos] = ch[i];
            pos++;
        end
        if (c.parity_en) begin
            f[pos] = parity_of(ch, c) ^ bad_parity;
            pos++;
        end
        f[pos] = ~bad_stop;
        return f;
    endfunction

    // sends one frame, loaded or banged, watching txd and the receiver every clock.
    task automatic run_frame(input string name, input uart_char_t ch, input logic banged,
                             input logic bad_parity, input logic bad_stop,
                             output logic got_valid, output rx_error_t got_error,
                             output uart_char_t got_char);
        logic [11:0] f;
        int          len;
        int          low_at;
        int          k;
        logic        done_seen;
        f = frame_bits(ch, cfg, bad_parity, bad_stop);
        len = frame_length(cfg);
        low_at = -1;
        done_seen = banged;
        got_valid = 1'b0;
        got_error = '0;
        got_char = '0;
        loop_sel = ~banged;
        if (!banged) begin
            tx_char = ch;
            tx_load = 1'b1;
        end
        for (int n = 0; n < 2 * len * BIT_CLOCKS; n++) begin
            if (banged) begin
                bb_line = (n < len * BIT_CLOCKS) ? f[n / BIT_CLOCKS] : 1'b1;
            end
            next_clocks(1);
            tx_load = 1'b0;
            if (!banged && low_at < 0 && txd == 1'b0) begin
                low_at = n;
            end
            k = (n - low_at) / BIT_CLOCKS;
            // mid-bit, counted from the first low txd.
            if (low_at >= 0 && k < len && (n - low_at) % BIT_CLOCKS == BIT_CLOCKS / 2) begin
                check_bit($sformatf("%s txd bit %0d", name, k), f[k], txd);
            end
            if (tx_done && !done_seen) begin
                done_seen = 1'b1;
                check_bit({name, " tx_busy at done"}, 1'b0, tx_busy);
            end
            if (!got_valid && got_error == '0) begin
                got_valid = rx_valid;
                got_error = rx_error;
                got_char = rx_char;
            end
            if (done_seen && (got_valid || got_error != '0) && n >= len * BIT_CLOCKS) begin
                break;
            end
        end
        if (!banged && low_at < 0) begin
            note_failure({name, ": txd never went low after load"});
        end else if (!done_seen) begin
            note_failure({name, ": tx_done never pulsed"});
        end
    endtask

    `include "tb_uart_tests.svh"

    initial begin
        clock = 1'b0;
        reset_in = 1'b1;
        baud_div = BAUD_WIDTH'(BIT_CLOCKS - 1);
        cfg = '0;
        tx_char = '0;
        tx_load = 1'b0;
        loop_sel = 1'b1;
        bb_line = 1'b1;
        error_count = 0;
        void'($urandom(32'h4865_174c));
        apply_reset();
        test_reset_state();
        test_tx_framing();
        test_loopback();
        test_parity_error();
        test_stop_error();
        test_line_low();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("errors: %0d", error_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* source/uart_top.sv */
`timescale 1ns/1ps

module uart_top #(
    parameter int BAUD_WIDTH = 21
) (
    input  logic                  clock,
    input  logic                  reset_in,
    input  logic [BAUD_WIDTH-1:0] baud_div,
    input  uart_pkg::line_cfg_t   cfg,
    input  uart_pkg::uart_char_t  tx_char,
    input  logic                  tx_load,
    output logic                  txd,
    output logic                  tx_busy,
    output logic                  tx_done,
    input  logic                  rxd,
    output uart_pkg::uart_char_t  rx_char,
    output logic                  rx_valid,
    output uart_pkg::rx_error_t   rx_error
);

    logic tx_restart;
    logic tx_tick;
    logic rx_restart_half;
    logic rx_tick;

    // transmit side only ever needs a full-period restart.
    bit_timer #(
        .BAUD_WIDTH(BAUD_WIDTH)
    ) u_tx_timer (
        .clock       (clock),
        .reset_in    (reset_in),
        .baud_div    (baud_div),
        .restart     (tx_restart),
        .restart_half(1'b0),
        .tick        (tx_tick)
    );

    // receive side free-runs and re-times on the start edge.
    bit_timer #(
        .BAUD_WIDTH(BAUD_WIDTH)
    ) u_rx_timer (
        .clock       (clock),
        .reset_in    (reset_in),
        .baud_div    (baud_div),
        .restart     (1'b0),
        .restart_half(rx_restart_half),
        .tick        (rx_tick)
    );

    uart_tx u_tx (
        .clock   (clock),
        .reset_in(reset_in),
        .cfg     (cfg),
        .tick    (tx_tick),
        .char    (tx_char),
        .load    (tx_load),
        .restart (tx_restart),
        .txd     (txd),
        .busy    (tx_busy),
        .done    (tx_done)
    );

    uart_rx u_rx (
        .clock       (clock),
        .reset_in    (reset_in),
        .cfg         (cfg),
        .tick        (rx_tick),
        .rxd         (rxd),
        .restart_half(rx_restart_half),
        .char        (rx_char),
        .valid       (rx_valid),
        .error       (rx_error)
    );

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clock,
    input  logic                 reset_in,
    input  uart_pkg::line_cfg_t  cfg,
    input  logic                 tick,
    input  logic                 rxd,
    output logic                 restart_half,
    output uart_pkg::uart_char_t char,
    output logic                 valid,
    output uart_pkg::rx_error_t  error
);

    import uart_pkg::*;

    typedef enum logic [2:0] {
        HUNT,
        START_WAIT,
        START,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

    rx_state_t  state;
    logic [1:0] rxd_sync;
    logic       line;
    logic [3:0] n_bits;
    logic [3:0] bit_cnt;
    uart_char_t shreg;
    uart_char_t data;

    assign line = rxd_sync[1];
    assign n_bits = char_bits(cfg.char_size);

    // data enters at the top, so short characters need aligning.
    assign data = shreg >> (4'(CHAR_WIDTH) - n_bits);

    // falling edge seen between the two sync flops.
    assign restart_half = (state == START_WAIT) && rxd_sync[1] && !rxd_sync[0];

    always_ff @(posedge clock) begin
        rxd_sync <= {rxd_sync[0], rxd};
    end

    always_ff @(posedge clock) begin
        if (state == DATA && tick) begin
            shreg <= {line, shreg[CHAR_WIDTH-1:1]};
        end
        if (state == STOP && tick && line) begin
            char <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_in) begin
            state <= HUNT;
            bit_cnt <= '0;
            valid <= 1'b0;
            error <= '0;
        end else begin
            valid <= 1'b0;
            error <= '0;
            case (state)
                HUNT: begin
                    // need one idle-high bit period first.
                    if (tick) begin
                        if (line) begin
                            state <= START_WAIT;
                        end else begin
                            error.line_low <= 1'b1;
                        end
                    end
                end
                START_WAIT: begin
                    if (restart_half) begin
                        state <= START;
                    end
                end
                START: begin
                    if (tick) begin
                        if (line) begin
                            // glitch, not a start bit.
                            state <= START_WAIT;
                        end else begin
                            state <= DATA;
                            bit_cnt <= '0;
                        end
                    end
                end
                DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == n_bits - 4'd1) begin
                            state <= cfg.parity_en ? PARITY : STOP;
                        end
                    end
                end
                PARITY: begin
                    if (tick) begin
                        if (line != char_parity(data, cfg)) begin
                            error.parity_err <= 1'b1;
                            state <= HUNT;
                        end else begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (tick) begin
                        if (line) begin
                            valid <= 1'b1;
                            state <= START_WAIT;
                        end else begin
                            error.stop_err <= 1'b1;
                            state <= HUNT;
                        end
                    end
                end
                default: begin
                    state <= HUNT;
                end
            endcase
        end
    end

    // a frame ends either good or with one reason.
    a_valid_or_error : assert property (
        @(posedge clock) disable iff (reset_in)
        !(valid && (error != '0))
    );

    a_one_error : assert property (
        @(posedge clock) disable iff (reset_in)
        $onehot0(error)
    );

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clock,
    input  logic                 reset_in,
    input  uart_pkg::line_cfg_t  cfg,
    input  logic                 tick,
    input  uart_pkg::uart_char_t char,
    input  logic                 load,
    output logic                 restart,
    output logic                 txd,
    output logic                 busy,
    output logic                 done
);

    import uart_pkg::*;

    logic [3:0]             n_bits;
    logic [3:0]             stop_pos;
    logic                   parity_bit;
    logic [1:0]             stop_bits;
    logic [FRAME_WIDTH-1:0] frame;
    logic [FRAME_WIDTH-1:0] shreg;

    // frame after the start bit, LSB goes out first.
    always_comb begin
        n_bits = char_bits(cfg.char_size);
        stop_pos = n_bits + 4'(cfg.parity_en);
        parity_bit = cfg.parity_en & char_parity(char, cfg);
        stop_bits = cfg.two_stop ? 2'b11 : 2'b01;
        frame = FRAME_WIDTH'(char) & ((FRAME_WIDTH'(1) << n_bits) - FRAME_WIDTH'(1));
        frame = frame | (FRAME_WIDTH'(parity_bit) << n_bits);
        frame = frame | (FRAME_WIDTH'(stop_bits) << stop_pos);
    end

    // start bit lasts a full period from here.
    assign restart = load & ~busy;

    always_ff @(posedge clock) begin
        if (restart) begin
            shreg <= frame;
        end else if (busy && tick) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_in) begin
            txd <= 1'b1;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (load) begin
                    txd <= 1'b0;
                    busy <= 1'b1;
                end
            end else if (tick) begin
                if (shreg == '0) begin
                    // end of the last stop bit.
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    txd <= shreg[0];
                end
            end
        end
    end

    // the line only leaves idle inside a frame.
    a_idle_high : assert property (
        @(posedge clock) disable iff (reset_in)
        !busy |-> txd
    );

endmodule

/* source/bit_timer.sv */
`timescale 1ns/1ps

module bit_timer #(
    parameter int BAUD_WIDTH = 21
) (
    input  logic                  clock,
    input  logic                  reset_in,
    input  logic [BAUD_WIDTH-1:0] baud_div,
    input  logic                  restart,
    input  logic                  restart_half,
    output logic                  tick
);

    logic [BAUD_WIDTH-1:0] count;

    assign tick = (count == '0);

    always_ff @(posedge clock) begin
        if (reset_in) begin
            count <= '0;
        end else if (restart) begin
            count <= baud_div;
        end else if (restart_half) begin
            // next tick lands mid-bit.
            count <= baud_div >> 1;
        end else if (tick) begin
            count <= baud_div;
        end else begin
            count <= count - 1'b1;
        end
    end

    // each timer has a single owner, which never asks for both reloads.
    a_one_restart : assert property (
        @(posedge clock) disable iff (reset_in)
        !(restart && restart_half)
    );

endmodule

/* source/uart_pkg.sv */
package uart_pkg;

    localparam int CHAR_WIDTH = 8;

    // data, parity and up to two stop bits, start bit excluded.
    localparam int FRAME_WIDTH = 11;

    typedef enum logic [1:0] {
        CHAR_5 = 2'b00,
        CHAR_6 = 2'b01,
        CHAR_7 = 2'b10,
        CHAR_8 = 2'b11
    } char_size_t;

    typedef struct packed {
        char_size_t char_size;
        logic       parity_en;
        logic       parity_odd;
        logic       two_stop;
    } line_cfg_t;

    // one flag per error pulse.
    typedef struct packed {
        logic line_low;
        logic stop_err;
        logic parity_err;
    } rx_error_t;

    typedef logic [CHAR_WIDTH-1:0] uart_char_t;

    function automatic logic [3:0] char_bits(char_size_t size);
        return 4'd5 + 4'(size);
    endfunction

    // even parity unless parity_odd.
    function automatic logic char_parity(uart_char_t ch, line_cfg_t cfg);
        logic p;
        p = cfg.parity_odd;
        for (int i = 0; i < CHAR_WIDTH; i++) begin
            if (i < int'(char_bits(cfg.char_size))) begin
                p = p ^ ch[i];
            end
        end
        return p;
    endfunction

endpackage
